// ==== rtl/dbus_pkg.sv ====
package dbus_pkg;

  // Data bus widths
  localparam int unsigned XLEN     = 32;
  localparam int unsigned MASK_W   = XLEN / 8;   // One enable per byte lane

  // Peripherals are decoded on 4 KiB pages
  localparam int unsigned PAGE_LSB = 12;

  // Request from the core data bus towards a peripheral.
  // The host holds every field stable while req is high.
  typedef struct packed {
    logic              req;     // Four-phase request
    logic              wr;      // 1 = write, 0 = read
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   w_data;
    logic [MASK_W-1:0] mask;    // Byte enables
  } dbus2peri_s;

  // Response from a peripheral back to the data bus
  typedef struct packed {
    logic              ack;     // Held high until req drops
    logic              err;     // Only valid together with ack
    logic [XLEN-1:0]   r_data;  // Zero for writes and errors
  } peri2dbus_s;

endpackage : dbus_pkg

// ==== rtl/gpio_pkg.sv ====
package gpio_pkg;

  // Number of GPIO pins
  localparam int unsigned GPIO_W = 8;

  // Offset and page split follow the bus page size
  localparam int unsigned OFFS_W = dbus_pkg::PAGE_LSB;
  localparam int unsigned PAGE_W = dbus_pkg::XLEN - dbus_pkg::PAGE_LSB;

  // Upper address bits of the GPIO page
  localparam logic [PAGE_W-1:0] GPIO_PAGE = 20'h40000;

  // Register map, byte offsets inside the page
  localparam logic [OFFS_W-1:0] REG_OUT = 12'h000;  // Output value
  localparam logic [OFFS_W-1:0] REG_DIR = 12'h004;  // 1 = pin drives
  localparam logic [OFFS_W-1:0] REG_IN  = 12'h008;  // Synchronized pads, read only
  localparam logic [OFFS_W-1:0] REG_IE  = 12'h00C;  // Interrupt enable
  localparam logic [OFFS_W-1:0] REG_IS  = 12'h010;  // Interrupt status, write 1 to clear

endpackage : gpio_pkg

// ==== rtl/dbus_decoder.sv ====
`timescale 1ns/1ns

module dbus_decoder (
  input  logic                 clk,
  input  logic                 rst_n,

  // Host side
  input  dbus_pkg::dbus2peri_s host_req_i,
  output dbus_pkg::peri2dbus_s host_rsp_o,

  // GPIO block side
  output dbus_pkg::dbus2peri_s gpio_req_o,
  input  dbus_pkg::peri2dbus_s gpio_rsp_i
);

  logic page_hit;     // Request addresses the GPIO page
  logic err_ack_q;    // Ack of the error responder
  logic gpio_sel_q;   // Page of the transaction in flight

  // Page compare on the upper address bits
  assign page_hit =
    (host_req_i.addr[dbus_pkg::XLEN-1:dbus_pkg::PAGE_LSB] == gpio_pkg::GPIO_PAGE);

  // Forward everything, but only raise req towards GPIO on a page match
  always_comb begin
    gpio_req_o     = host_req_i;
    gpio_req_o.req = host_req_i.req & page_hit;
  end

  // Error responder for every other page.
  // Same four-phase timing as a real target: ack follows req by one edge.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_ack_q <= 1'b0;
    end else begin
      err_ack_q <= host_req_i.req & ~page_hit;
    end
  end

  // Remember which side owns the transaction.
  // The host may change addr once req drops, while ack is still high.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gpio_sel_q <= 1'b0;
    end else if (host_req_i.req) begin
      gpio_sel_q <= page_hit;
    end
  end

  // Response return
  always_comb begin
    if (gpio_sel_q) begin
      host_rsp_o = gpio_rsp_i;
    end else begin
      host_rsp_o = '{ack: err_ack_q, err: err_ack_q, r_data: '0};
    end
  end

endmodule : dbus_decoder

// ==== rtl/gpio_regs.sv ====
`timescale 1ns/1ns

module gpio_regs (
  input  logic                        clk,
  input  logic                        rst_n,

  // Bus port, already selected by the decoder
  input  dbus_pkg::dbus2peri_s        bus_req_i,
  output dbus_pkg::peri2dbus_s        bus_rsp_o,

  // From the port logic
  input  logic [gpio_pkg::GPIO_W-1:0] pin_state_i,
  input  logic [gpio_pkg::GPIO_W-1:0] rise_i,

  // To pads and port logic
  output logic [gpio_pkg::GPIO_W-1:0] dir_o,
  output logic [gpio_pkg::GPIO_W-1:0] out_o,
  output logic                        irq_o
);

  logic [gpio_pkg::OFFS_W-1:0] offset;
  logic                        start;     // First cycle of a request
  logic                        hit;       // Offset is a known register
  logic                        wr_en;
  logic [gpio_pkg::GPIO_W-1:0] wdata;
  logic [dbus_pkg::XLEN-1:0]   rd_word;

  logic [gpio_pkg::GPIO_W-1:0] out_q;
  logic [gpio_pkg::GPIO_W-1:0] dir_q;
  logic [gpio_pkg::GPIO_W-1:0] ie_q;
  logic [gpio_pkg::GPIO_W-1:0] is_q;
  logic [gpio_pkg::GPIO_W-1:0] ie_d;
  logic [gpio_pkg::GPIO_W-1:0] is_d;
  logic [gpio_pkg::GPIO_W-1:0] is_clr;
  logic                        irq_q;

  logic                        ack_q;
  logic                        err_q;
  logic [dbus_pkg::XLEN-1:0]   rdata_q;

  assign offset = bus_req_i.addr[gpio_pkg::OFFS_W-1:0];
  assign start  = bus_req_i.req & ~ack_q;
  assign wdata  = bus_req_i.w_data[gpio_pkg::GPIO_W-1:0];

  // Registers are one byte wide, so only lane 0 counts
  assign wr_en = start & bus_req_i.wr & bus_req_i.mask[0] & hit;

  // Offset decode and read mux
  always_comb begin
    hit     = 1'b1;
    rd_word = '0;
    case (offset)
      gpio_pkg::REG_OUT: rd_word[gpio_pkg::GPIO_W-1:0] = out_q;
      gpio_pkg::REG_DIR: rd_word[gpio_pkg::GPIO_W-1:0] = dir_q;
      gpio_pkg::REG_IN:  rd_word[gpio_pkg::GPIO_W-1:0] = pin_state_i;
      gpio_pkg::REG_IE:  rd_word[gpio_pkg::GPIO_W-1:0] = ie_q;
      gpio_pkg::REG_IS:  rd_word[gpio_pkg::GPIO_W-1:0] = is_q;
      default:           hit = 1'b0;
    endcase
  end

  // Next IE and IS, a new edge beats a clear in the same cycle
  assign ie_d   = (wr_en && offset == gpio_pkg::REG_IE) ? wdata : ie_q;
  assign is_clr = (wr_en && offset == gpio_pkg::REG_IS) ? wdata : '0;
  assign is_d   = (is_q & ~is_clr) | rise_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_q <= '0;
      dir_q <= '0;
      ie_q  <= '0;
      is_q  <= '0;
      irq_q <= 1'b0;
    end else begin
      if (wr_en && offset == gpio_pkg::REG_OUT) out_q <= wdata;
      if (wr_en && offset == gpio_pkg::REG_DIR) dir_q <= wdata;
      ie_q  <= ie_d;
      is_q  <= is_d;
      irq_q <= |(is_d & ie_d);   // Rises on the edge that sets IS
    end
  end

  // Four-phase handshake, ack simply trails req by one edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= bus_req_i.req;
      if (start) begin
        err_q <= ~hit;
      end else if (!bus_req_i.req) begin
        err_q <= 1'b0;
      end
    end
  end

  // Read data captured once and held while ack is high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (start) begin
      rdata_q <= (hit && !bus_req_i.wr) ? rd_word : '0;
    end
  end

  assign bus_rsp_o = '{ack: ack_q, err: err_q, r_data: rdata_q};
  assign out_o     = out_q;
  assign dir_o     = dir_q;
  assign irq_o     = irq_q;

endmodule : gpio_regs

// ==== rtl/gpio_port.sv ====
`timescale 1ns/1ns

module gpio_port (
  input  logic                        clk,
  input  logic                        rst_n,

  // Raw pad inputs, asynchronous to clk
  input  logic [gpio_pkg::GPIO_W-1:0] gpio_pad_i,

  // Pin direction from the register block, 1 = output
  input  logic [gpio_pkg::GPIO_W-1:0] dir_i,

  output logic [gpio_pkg::GPIO_W-1:0] pin_state_o,
  output logic [gpio_pkg::GPIO_W-1:0] rise_o
);

  logic [gpio_pkg::GPIO_W-1:0] meta_q;   // First synchronizer stage
  logic [gpio_pkg::GPIO_W-1:0] sync_q;   // Second stage, safe to use
  logic [gpio_pkg::GPIO_W-1:0] prev_q;   // Last cycle's synchronized value

  // Two-flop synchronizer per pad.
  // Cleared so that no edge is seen right after reset.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= gpio_pad_i;
      sync_q <= meta_q;
    end
  end

  // Previous state for edge detection
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prev_q <= '0;
    end else begin
      prev_q <= sync_q;
    end
  end

  assign pin_state_o = sync_q;

  // One-cycle pulse on 0 to 1, input pins only
  assign rise_o = sync_q & ~prev_q & ~dir_i;

endmodule : gpio_port

// ==== rtl/gpio_subsys.sv ====
`timescale 1ns/1ns

module gpio_subsys (
  input  logic                        clk,
  input  logic                        rst_n,

  // Data bus from the core
  input  dbus_pkg::dbus2peri_s        host_req_i,
  output dbus_pkg::peri2dbus_s        host_rsp_o,

  // Pads
  input  logic [gpio_pkg::GPIO_W-1:0] gpio_pad_i,
  output logic [gpio_pkg::GPIO_W-1:0] gpio_pad_o,
  output logic [gpio_pkg::GPIO_W-1:0] gpio_oe_o,

  output logic                        irq_o
);

  dbus_pkg::dbus2peri_s        gpio_req;
  dbus_pkg::peri2dbus_s        gpio_rsp;
  logic [gpio_pkg::GPIO_W-1:0] dir;
  logic [gpio_pkg::GPIO_W-1:0] pin_state;
  logic [gpio_pkg::GPIO_W-1:0] rise;

  dbus_decoder u_decoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_req_i (host_req_i),
    .host_rsp_o (host_rsp_o),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp)
  );

  gpio_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus_req_i   (gpio_req),
    .bus_rsp_o   (gpio_rsp),
    .pin_state_i (pin_state),
    .rise_i      (rise),
    .dir_o       (dir),
    .out_o       (gpio_pad_o),  // OUT drives the pads directly
    .irq_o       (irq_o)
  );

  gpio_port u_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .gpio_pad_i  (gpio_pad_i),
    .dir_i       (dir),
    .pin_state_o (pin_state),
    .rise_o      (rise)
  );

  assign gpio_oe_o = dir;   // Output enable is DIR

endmodule : gpio_subsys

// ==== test/gpio_subsys_assert.sv ====
`timescale 1ns/1ns

module gpio_subsys_assert (
  input logic                        clk,
  input logic                        rst_n,
  input dbus_pkg::dbus2peri_s        host_req_i,
  input dbus_pkg::peri2dbus_s        host_rsp_o,
  input logic [gpio_pkg::GPIO_W-1:0] gpio_oe_o
);

  // ack only answers a request seen on the previous edge
  ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(host_rsp_o.ack) |-> $past(host_req_i.req)
  ) else $error("ack rose without a request on the previous edge");

  ack_follows_req_low: assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(host_req_i.req) |=> !host_rsp_o.ack
  ) else $error("ack still high one cycle after req fell");

  // err is part of the response, never on its own
  err_with_ack: assert property (
    @(posedge clk) disable iff (!rst_n)
    host_rsp_o.err |-> host_rsp_o.ack
  ) else $error("err high without ack");

  // Pads stay undriven through reset
  oe_low_in_reset: assert property (
    @(posedge clk)
    !rst_n |=> (gpio_oe_o == '0)
  ) else $error("gpio_oe_o not zero during reset");

endmodule : gpio_subsys_assert

bind gpio_subsys gpio_subsys_assert u_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .host_req_i (host_req_i),
  .host_rsp_o (host_rsp_o),
  .gpio_oe_o  (gpio_oe_o)
);

// ==== test/gpio_subsys_tb.sv ====
`timescale 1ns/1ns

module gpio_subsys_tb;

  localparam logic [1:0] OP_RD  = 2'd0;
  localparam logic [1:0] OP_WR  = 2'd1;
  localparam logic [1:0] OP_PAD = 2'd2;

  localparam int  RST_CYCLES = 16;
  localparam int  ROW_CYCLES = 20;   // Run limit per table row
  localparam int  ACK_WAIT   = 8;
  localparam time DRIVE_DLY  = 1;    // Inputs change just after the edge

  typedef struct packed {
    logic [1:0]                  op;
    logic [3:0]                  hold;       // Cycles req stays high after ack
    logic [dbus_pkg::XLEN-1:0]   addr;
    logic [dbus_pkg::XLEN-1:0]   wdata;
    logic [dbus_pkg::MASK_W-1:0] mask;
    logic [gpio_pkg::GPIO_W-1:0] pad;        // Also driven while a held req waits
    logic [dbus_pkg::XLEN-1:0]   exp_rdata;
    logic                        exp_err;
    logic [gpio_pkg::GPIO_W-1:0] exp_pad_o;
    logic [gpio_pkg::GPIO_W-1:0] exp_oe_o;
    logic                        exp_irq;
  } row_s;

  logic                        clk;
  logic                        rst_n;
  dbus_pkg::dbus2peri_s        host_req;
  dbus_pkg::peri2dbus_s        host_rsp;
  logic [gpio_pkg::GPIO_W-1:0] gpio_pad;
  logic [gpio_pkg::GPIO_W-1:0] gpio_pad_o;
  logic [gpio_pkg::GPIO_W-1:0] gpio_oe_o;
  logic                        irq;

  row_s        rows[$];
  int          tests;
  int          errors;
  int          cycles = 0;
  int          cycle_limit;
  logic [31:0] lcg_state;

  // Expected register contents
  logic [gpio_pkg::GPIO_W-1:0] m_out;
  logic [gpio_pkg::GPIO_W-1:0] m_dir;
  logic [gpio_pkg::GPIO_W-1:0] m_ie;
  logic [gpio_pkg::GPIO_W-1:0] m_is;
  logic [gpio_pkg::GPIO_W-1:0] m_pad;

  gpio_subsys dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_req_i (host_req),
    .host_rsp_o (host_rsp),
    .gpio_pad_i (gpio_pad),
    .gpio_pad_o (gpio_pad_o),
    .gpio_oe_o  (gpio_oe_o),
    .irq_o      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run went past %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [gpio_pkg::OFFS_W-1:0] offs);
    return {gpio_pkg::GPIO_PAGE, offs};
  endfunction

  function automatic string op_name(input logic [1:0] op);
    case (op)
      OP_RD:   return "read";
      OP_WR:   return "write";
      default: return "pad";
    endcase
  endfunction

  // Register view from the map, hit low for offsets outside it
  function automatic logic [gpio_pkg::GPIO_W-1:0] model_read(
    input logic [gpio_pkg::OFFS_W-1:0] offs, output logic hit);
    logic [gpio_pkg::GPIO_W-1:0] val;
    hit = 1'b1;
    val = '0;
    case (offs)
      gpio_pkg::REG_OUT: val = m_out;
      gpio_pkg::REG_DIR: val = m_dir;
      gpio_pkg::REG_IN:  val = m_pad;   // Pads held long enough to be synced
      gpio_pkg::REG_IE:  val = m_ie;
      gpio_pkg::REG_IS:  val = m_is;
      default:           hit = 1'b0;
    endcase
    return val;
  endfunction

  // Appends one row and advances the model to the state after it
  task automatic add_row(input logic [1:0] op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] mask,
                         input logic [7:0] pad, input logic [3:0] hold);
    row_s                        r;
    logic                        hit;
    logic [gpio_pkg::GPIO_W-1:0] val;
    logic [gpio_pkg::OFFS_W-1:0] offs;
    r = '0;
    offs = addr[gpio_pkg::OFFS_W-1:0];
    val = model_read(offs, hit);
    hit = hit && (addr[dbus_pkg::XLEN-1:dbus_pkg::PAGE_LSB] == gpio_pkg::GPIO_PAGE);
    r.op = op;
    r.hold = hold;
    r.addr = addr;
    r.wdata = wdata;
    r.mask = mask;
    r.pad = pad;
    if (op == OP_PAD) begin
      m_is  = m_is | (pad & ~m_pad & ~m_dir);   // Rising input pins only
      m_pad = pad;
    end else if (!hit) begin
      r.exp_err = 1'b1;
    end else if (op == OP_RD) begin
      r.exp_rdata[gpio_pkg::GPIO_W-1:0] = val;
    end else if (mask[0]) begin
      case (offs)
        gpio_pkg::REG_OUT: m_out = wdata[gpio_pkg::GPIO_W-1:0];
        gpio_pkg::REG_DIR: m_dir = wdata[gpio_pkg::GPIO_W-1:0];
        gpio_pkg::REG_IE:  m_ie  = wdata[gpio_pkg::GPIO_W-1:0];
        gpio_pkg::REG_IS:  m_is  = m_is & ~wdata[gpio_pkg::GPIO_W-1:0];
        default: ;   // IN ignores writes
      endcase
    end
    if (op != OP_PAD && hold != 4'd0) begin
      m_is  = m_is | (pad & ~m_pad & ~m_dir);   // Pad change after the access
      m_pad = pad;
    end
    r.exp_pad_o = m_out;
    r.exp_oe_o  = m_dir;
    r.exp_irq   = |(m_is & m_ie);
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Reset state
    add_row(OP_RD, reg_addr(gpio_pkg::REG_OUT), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_DIR), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_IN), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_IE), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_IS), 32'h0, 4'hF, 8'h00, 4'd0);
    // Write and readback, masked writes must not land
    add_row(OP_WR, reg_addr(gpio_pkg::REG_OUT), lcg_next(), 4'hF, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_OUT), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_WR, reg_addr(gpio_pkg::REG_DIR), 32'hF0, 4'hF, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_DIR), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_WR, reg_addr(gpio_pkg::REG_OUT), lcg_next(), 4'h0, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_OUT), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_WR, reg_addr(gpio_pkg::REG_OUT), lcg_next(), 4'hE, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_OUT), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_WR, reg_addr(gpio_pkg::REG_OUT), lcg_next(), 4'h1, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_OUT), 32'h0, 4'hF, 8'h00, 4'd0);
    // Input pins
    add_row(OP_PAD, 32'h0, 32'h0, 4'h0, 8'h05, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_IN), 32'h0, 4'hF, 8'h00, 4'd0);
    // Error responses, state must survive them
    add_row(OP_RD, 32'h4000_1000, 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_WR, 32'h0000_0000, 32'hFF, 4'hF, 8'h00, 4'd0);
    add_row(OP_WR, reg_addr(12'h014), 32'hFF, 4'hF, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(12'h020), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_WR, reg_addr(gpio_pkg::REG_IN), 32'hAA, 4'hF, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_OUT), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_DIR), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_IN), 32'h0, 4'hF, 8'h00, 4'd0);
    // Interrupts
    add_row(OP_WR, reg_addr(gpio_pkg::REG_IS), 32'hFF, 4'hF, 8'h00, 4'd0);
    add_row(OP_WR, reg_addr(gpio_pkg::REG_IE), 32'hFF, 4'hF, 8'h00, 4'd0);
    add_row(OP_PAD, 32'h0, 32'h0, 4'h0, 8'h0F, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_IS), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_WR, reg_addr(gpio_pkg::REG_IS), 32'h0A, 4'hF, 8'h00, 4'd0);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_IS), 32'h0, 4'hF, 8'h00, 4'd0);
    add_row(OP_PAD, 32'h0, 32'h0, 4'h0, 8'hF0, 4'd0);   // Output pins rise
    add_row(OP_RD, reg_addr(gpio_pkg::REG_IS), 32'h0, 4'hF, 8'h00, 4'd0);
    // Back-pressure
    add_row(OP_PAD, 32'h0, 32'h0, 4'h0, 8'hF3, 4'd0);
    // Pin 2 rises while req is held, a repeated clear would wipe it
    add_row(OP_WR, reg_addr(gpio_pkg::REG_IS), 32'h07, 4'hF, 8'hF7, 4'd4);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_IS), 32'h0, 4'hF, 8'hF7, 4'd3);
    add_row(OP_WR, reg_addr(gpio_pkg::REG_OUT), lcg_next(), 4'hF, 8'hF7, 4'd3);
    add_row(OP_RD, reg_addr(gpio_pkg::REG_OUT), 32'h0, 4'hF, 8'hF7, 4'd2);
  endtask

  // One four-phase transfer, returns after ack is low again
  task automatic bus_xfer(input row_s r, output logic acked,
                          output dbus_pkg::peri2dbus_s rsp);
    int waited;
    @(posedge clk);
    #DRIVE_DLY;
    host_req.req = 1'b1;
    host_req.wr = (r.op == OP_WR);
    host_req.addr = r.addr;
    host_req.w_data = r.wdata;
    host_req.mask = r.mask;
    waited = 0;
    while (!host_rsp.ack && waited < ACK_WAIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end
    if (host_rsp.ack && waited != 1) begin
      $display("ack took %0d cycles to rise instead of 1", waited);
      errors++;
    end
    acked = host_rsp.ack;
    rsp = host_rsp;
    if (r.hold != 4'd0) begin
      gpio_pad = r.pad;
    end
    repeat (r.hold) begin
      @(posedge clk);
      #DRIVE_DLY;
      if (!host_rsp.ack) begin
        $display("ack dropped while req was still held");
        errors++;
      end
    end
    host_req = '0;
    waited = 0;
    while (host_rsp.ack && waited < ACK_WAIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end
    if (host_rsp.ack) begin
      $display("ack stayed high after req was dropped");
      errors++;
    end
  endtask

  task automatic run_row(input int idx);
    row_s                 r;
    dbus_pkg::peri2dbus_s rsp;
    logic                 acked;
    int                   errs_before;
    r = rows[idx];
    errs_before = errors;
    if (r.op == OP_PAD) begin
      @(posedge clk);
      #DRIVE_DLY;
      gpio_pad = r.pad;
      repeat (3) @(posedge clk);   // Sync, edge detect, then IS
      #DRIVE_DLY;
    end else begin
      bus_xfer(r, acked, rsp);
      if (!acked) begin
        $display("Row %0d got no ack from the DUT within %0d cycles", idx, ACK_WAIT);
        errors++;
      end else begin
        if (rsp.r_data !== r.exp_rdata) begin
          $display("MISMATCH row %0d r_data: got %h expected %h", idx, rsp.r_data, r.exp_rdata);
          errors++;
        end
        if (rsp.err !== r.exp_err) begin
          $display("MISMATCH row %0d err: got %h expected %h", idx, rsp.err, r.exp_err);
          errors++;
        end
      end
    end
    if (gpio_pad_o !== r.exp_pad_o) begin
      $display("MISMATCH row %0d gpio_pad_o: got %h expected %h", idx, gpio_pad_o, r.exp_pad_o);
      errors++;
    end
    if (gpio_oe_o !== r.exp_oe_o) begin
      $display("MISMATCH row %0d gpio_oe_o: got %h expected %h", idx, gpio_oe_o, r.exp_oe_o);
      errors++;
    end
    if (irq !== r.exp_irq) begin
      $display("MISMATCH row %0d irq_o: got %h expected %h", idx, irq, r.exp_irq);
      errors++;
    end
    tests++;
    $display("Row %0d %s at %h: %s", idx, op_name(r.op), r.addr,
             (errors == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    rst_n = 1'b0;
    host_req = '0;
    gpio_pad = '0;
    tests = 0;
    errors = 0;
    lcg_state = 32'hf7f8;
    m_out = '0;
    m_dir = '0;
    m_ie = '0;
    m_is = '0;
    m_pad = '0;
    build_table();
    cycle_limit = RST_CYCLES + ROW_CYCLES * rows.size();
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    foreach (rows[i]) begin
      run_row(i);
    end
    $display("Rows run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : gpio_subsys_tb

// ==== sim.f ====
rtl/dbus_pkg.sv
rtl/gpio_pkg.sv
rtl/dbus_decoder.sv
rtl/gpio_regs.sv
rtl/gpio_port.sv
rtl/gpio_subsys.sv
test/gpio_subsys_assert.sv
test/gpio_subsys_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the GPIO subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module gpio_subsys_tb \
  -f sim.f

out=$(./obj_dir/Vgpio_subsys_tb 2>&1)
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
else
  exit 1
fi
